// ==== verilog.f ====
verilog/kiwi_pkg.sv
verilog/kiwi_decoder.sv
verilog/kiwi_scoreboard.sv
verilog/kiwi_operands.sv
verilog/kiwi_alu.sv
verilog/kiwi_core.sv
tests/kiwi_checker.sv
tests/tb_kiwi.sv

// ==== run.sh ====
#!/bin/sh
# build and run the kiwi testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_kiwi \
    --Mdir obj_dir -o tb_kiwi

./obj_dir/tb_kiwi > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0

// ==== tests/tb_kiwi.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_kiwi import kiwi_pkg::*; ();

    // instructions sent over all tests
    localparam int N_INSTS    = 417;
    localparam int MAX_CYCLES = 20 * N_INSTS + 200;

    logic                  clk;
    logic                  rst_n_i;
    logic                  inst_valid_i;
    logic [ILEN-1:0]       inst_i;
    logic                  inst_ready_o;
    logic                  wb_valid_o;
    logic [REG_ADDR_W-1:0] wb_rd_o;
    logic [XLEN-1:0]       wb_value_o;

    logic [XLEN-1:0] ref_rf [NUM_REGS];
    integer          seed;
    int              cycles = 0;
    int              stall_cycles = 0;

    kiwi_core u_kiwi_core (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .inst_ready_o (inst_ready_o),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_value_o   (wb_value_o)
    );

    kiwi_checker u_kiwi_checker (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_ready_i (inst_ready_o),
        .wb_valid_i   (wb_valid_o),
        .wb_rd_i      (wb_rd_o),
        .wb_value_i   (wb_value_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not complete within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [ILEN-1:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                                 input logic [4:0] rs1, input logic [2:0] f3,
                                                 input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [ILEN-1:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                                 input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [ILEN-1:0] encode_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    // legal OP-IMM encoding, shifts get a 6-bit shamt
    function automatic logic [ILEN-1:0] imm_op_inst(input logic [2:0] f3, input logic [4:0] rd,
                                                    input logic [4:0] rs1, input logic [31:0] rnd);
        logic [11:0] imm;
        imm = rnd[11:0];
        if (f3 == 3'b001) begin
            imm = {6'b000000, rnd[5:0]};
        end else if (f3 == 3'b101) begin
            imm = {1'b0, rnd[20], 4'b0000, rnd[5:0]};
        end
        return encode_i(imm, rs1, f3, rd);
    endfunction

    function automatic logic [ILEN-1:0] reg_op_inst(input logic [2:0] f3, input logic alt,
                                                    input logic [4:0] rd, input logic [4:0] rs1,
                                                    input logic [4:0] rs2);
        logic [6:0] f7;
        f7 = (alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
        return encode_r(f7, rs2, rs1, f3, rd);
    endfunction

    // RV64I semantics on the model register file, 0 when nothing retires
    function automatic bit expected_retire(input logic [ILEN-1:0] inst,
                                           output logic [4:0] rd, output logic [XLEN-1:0] value);
        logic [6:0]      opc;
        logic [2:0]      f3;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [5:0]      sh;
        opc   = inst[6:0];
        f3    = inst[14:12];
        rd    = inst[11:7];
        value = '0;
        a     = ref_rf[inst[19:15]];
        b     = (opc == OPC_OP) ? ref_rf[inst[24:20]] : {{52{inst[31]}}, inst[31:20]};
        sh    = b[5:0];
        if (opc == OPC_LUI) begin
            value = {{32{inst[31]}}, inst[31:12], 12'h000};
        end else if (opc == OPC_OP || opc == OPC_OP_IMM) begin
            case (f3)
                3'd0: value = (opc == OPC_OP && inst[30]) ? a - b : a + b;
                3'd1: value = a << sh;
                3'd2: value = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                3'd3: value = (a < b) ? 64'd1 : 64'd0;
                3'd4: value = a ^ b;
                3'd5: begin
                    if (inst[30]) begin
                        value = $signed(a) >>> sh;
                    end else begin
                        value = a >> sh;
                    end
                end
                3'd6: value = a | b;
                default: value = a & b;
            endcase
        end else begin
            return 1'b0;
        end
        if (rd == 5'd0) begin
            value = '0;
        end
        return 1'b1;
    endfunction

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic issue_inst(input logic [ILEN-1:0] inst);
        bit              known;
        logic [4:0]      rd;
        logic [XLEN-1:0] value;
        inst_valid_i = 1'b1;
        inst_i       = inst;
        while (!inst_ready_o) begin
            stall_cycles++;
            @(negedge clk);
        end
        @(negedge clk);
        inst_valid_i = 1'b0;
        known = expected_retire(inst, rd, value);
        if (known) begin
            u_kiwi_checker.push_expected(rd, value);
            if (rd != 5'd0) begin
                ref_rf[rd] = value;
            end
        end
    endtask

    task automatic finish_test(input string name);
        while (u_kiwi_checker.outstanding() != 0) begin
            @(negedge clk);
        end
        // room for a stray extra retire to show up
        repeat (6) @(negedge clk);
        u_kiwi_checker.close_test(name);
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] rnd2;
        logic [4:0]  rd;
        logic [4:0]  prev;
        int          stall_start;
        seed         = 32'ha6a5f9a9;
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            ref_rf[i] = '0;
        end
        repeat (16) @(negedge clk);
        rst_n_i = 1'b1;

        // idle window is checked by the checker
        repeat (8) @(negedge clk);
        for (int r = 0; r < NUM_REGS; r++) begin
            issue_inst(encode_i(12'h000, 5'(r), 3'b000, 5'(r)));
        end
        finish_test("reset");

        for (int k = 0; k < 4; k++) begin
            rnd = $random(seed);
            issue_inst(encode_u(rnd[19:0], 5'(k + 1)));
        end
        for (int k = 0; k < 24; k++) begin
            rnd = $random(seed);
            issue_inst(imm_op_inst(3'(k), 5'd1 + {2'b00, rnd[24:22]}, {2'b00, rnd[28:26]}, rnd));
        end
        finish_test("immediate ops");

        for (int k = 0; k < 24; k++) begin
            rnd = $random(seed);
            issue_inst(reg_op_inst(3'(k), (k / 8) % 2 == 1, 5'd1 + {2'b00, rnd[8:6]},
                                   {2'b00, rnd[15:13]}, {2'b00, rnd[18:16]}));
        end
        finish_test("register ops");

        // each instruction reads the previous destination
        stall_start = stall_cycles;
        prev        = 5'd3;
        for (int k = 0; k < 24; k++) begin
            rnd = $random(seed);
            rd  = 5'd1 + {2'b00, rnd[2:0]};
            if (k % 2 == 1) begin
                issue_inst(reg_op_inst(rnd[7:5], rnd[8], rd, prev, prev));
            end else begin
                issue_inst(imm_op_inst(rnd[7:5], rd, prev, rnd));
            end
            prev = rd;
        end
        if (stall_cycles == stall_start) begin
            u_kiwi_checker.report_fault("inst_ready_o never dropped during the dependent chain");
        end
        finish_test("hazard chain");

        issue_inst(encode_i(12'd123, 5'd1, 3'b000, 5'd0));
        issue_inst(encode_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
        issue_inst(encode_u(20'hfffff, 5'd0));
        issue_inst(encode_i(12'h405, 5'd3, 3'b101, 5'd0));
        // load, branch and an all-ones word
        issue_inst(32'h0000_3083);
        issue_inst(32'h0020_8063);
        issue_inst(32'hffff_ffff);
        issue_inst(encode_i(12'h000, 5'd0, 3'b000, 5'd8));
        issue_inst(encode_r(7'h00, 5'd0, 5'd0, 3'b110, 5'd9));
        finish_test("x0 and unknown");

        for (int k = 0; k < 300; k++) begin
            rnd = $random(seed);
            if (rnd[31:30] == 2'b00) begin
                repeat (int'(rnd[29:28]) + 1) @(negedge clk);
            end
            rnd  = $random(seed);
            rnd2 = $random(seed);
            rd   = {1'b0, rnd[21:18]};
            if (rnd[31:28] < 4'd6) begin
                issue_inst(reg_op_inst(rnd[24:22], rnd[25], rd, {1'b0, rnd[13:10]},
                                       {1'b0, rnd[17:14]}));
            end else if (rnd[31:28] < 4'd12) begin
                issue_inst(imm_op_inst(rnd[24:22], rd, {1'b0, rnd[13:10]}, rnd2));
            end else if (rnd[31:28] < 4'd15) begin
                issue_inst(encode_u(rnd2[19:0], rd));
            end else begin
                issue_inst(32'h0000_0073);
            end
        end
        finish_test("random program");

        u_kiwi_checker.print_totals();
        if (u_kiwi_checker.err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/kiwi_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module kiwi_checker import kiwi_pkg::*; (
    input wire                  clk,
    input wire                  rst_n_i,
    input wire                  inst_ready_i,
    input wire                  wb_valid_i,
    input wire [REG_ADDR_W-1:0] wb_rd_i,
    input wire [XLEN-1:0]       wb_value_i
);

    wb_t exp_q [$];
    int  err_count      = 0;
    int  test_errs      = 0;
    int  test_retired   = 0;
    int  test_expected  = 0;
    int  tests_run      = 0;
    int  tests_failed   = 0;
    int  total_retired  = 0;
    int  total_expected = 0;
    int  idle_left      = 0;

    task automatic report_error(input string msg);
        $display("ERR @%0t: %s", $time, msg);
        err_count++;
        test_errs++;
    endtask

    task automatic report_fault(input string msg);
        $display("%s", msg);
        err_count++;
        test_errs++;
    endtask

    task automatic push_expected(input logic [REG_ADDR_W-1:0] rd, input logic [XLEN-1:0] value);
        wb_t e;
        e.valid = 1'b1;
        e.rd    = rd;
        e.value = value;
        exp_q.push_back(e);
        test_expected++;
        total_expected++;
    endtask

    function automatic int outstanding();
        return exp_q.size();
    endfunction

    task automatic check_retire();
        wb_t e;
        test_retired++;
        total_retired++;
        if (exp_q.size() == 0) begin
            report_fault($sformatf("retire of x%0d at %0t with no instruction outstanding",
                                   wb_rd_i, $time));
        end else begin
            e = exp_q.pop_front();
            if (wb_rd_i != e.rd || wb_value_i != e.value) begin
                report_error($sformatf("retired x%0d = %h, expected x%0d = %h",
                                       wb_rd_i, wb_value_i, e.rd, e.value));
            end
        end
    endtask

    // outputs settle after the rising edge, sampled on the falling one
    always @(negedge clk) begin
        if (!rst_n_i) begin
            idle_left = 8;
        end else begin
            if (idle_left > 0) begin
                idle_left--;
                if (wb_valid_i || !inst_ready_i) begin
                    report_error($sformatf("after reset wb_valid %0b inst_ready %0b",
                                           wb_valid_i, inst_ready_i));
                end
            end
            if (wb_valid_i) begin
                check_retire();
            end
        end
    end

    task automatic close_test(input string name);
        if (test_retired != test_expected) begin
            report_fault($sformatf("test %s retired %0d records but %0d were expected",
                                   name, test_retired, test_expected));
        end
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s: ok, %0d retired", name, test_retired);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, test_errs);
        end
        test_errs     = 0;
        test_retired  = 0;
        test_expected = 0;
    endtask

    task automatic print_totals();
        if (total_retired != total_expected) begin
            report_fault($sformatf("retired %0d records in total but %0d were expected",
                                   total_retired, total_expected));
        end
        $display("tests %0d, failed %0d, retired %0d of %0d, errors %0d",
                 tests_run, tests_failed, total_retired, total_expected, err_count);
    endtask

endmodule

`default_nettype wire

// ==== verilog/kiwi_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module kiwi_core import kiwi_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n_i,
    input  wire                   inst_valid_i,
    input  wire [ILEN-1:0]        inst_i,
    output logic                  inst_ready_o,
    output logic                  wb_valid_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN-1:0]       wb_value_o
);

    logic [REG_ADDR_W-1:0] src_rs1;
    logic [REG_ADDR_W-1:0] src_rs2;
    logic                  src_use1;
    logic                  src_use2;
    logic                  hazard;
    dec_op_t               dec_op;
    exe_op_t               exe_op;
    wb_t                   wb;

    kiwi_decoder u_kiwi_decoder (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .inst_ready_o (inst_ready_o),
        .hazard_i     (hazard),
        .src_rs1_o    (src_rs1),
        .src_rs2_o    (src_rs2),
        .src_use1_o   (src_use1),
        .src_use2_o   (src_use2),
        .issue_o      (dec_op)
    );

    kiwi_scoreboard u_kiwi_scoreboard (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .src_rs1_i  (src_rs1),
        .src_rs2_i  (src_rs2),
        .src_use1_i (src_use1),
        .src_use2_i (src_use2),
        .issue_i    (dec_op),
        .wb_i       (wb),
        .hazard_o   (hazard)
    );

    kiwi_operands u_kiwi_operands (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .issue_i (dec_op),
        .wb_i    (wb),
        .exe_o   (exe_op)
    );

    kiwi_alu u_kiwi_alu (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .exe_i   (exe_op),
        .wb_o    (wb)
    );

    // retire port
    assign wb_valid_o = wb.valid;
    assign wb_rd_o    = wb.rd;
    assign wb_value_o = wb.value;

endmodule

`default_nettype wire

// ==== verilog/kiwi_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module kiwi_alu import kiwi_pkg::*; (
    input  wire          clk,
    input  wire          rst_n_i,
    input  wire exe_op_t exe_i,
    output wb_t          wb_o
);

    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    result;
    wb_t                wb_q;

    assign shamt = exe_i.op_b[SHAMT_W-1:0];

    always_comb begin
        case (exe_i.alu_op)
            ALU_ADD: begin
                result = exe_i.op_a + exe_i.op_b;
            end
            ALU_SUB: begin
                result = exe_i.op_a - exe_i.op_b;
            end
            ALU_SLL: begin
                result = exe_i.op_a << shamt;
            end
            ALU_SLT: begin
                result = {{(XLEN-1){1'b0}}, $signed(exe_i.op_a) < $signed(exe_i.op_b)};
            end
            ALU_SLTU: begin
                result = {{(XLEN-1){1'b0}}, exe_i.op_a < exe_i.op_b};
            end
            ALU_XOR: begin
                result = exe_i.op_a ^ exe_i.op_b;
            end
            ALU_SRL: begin
                result = exe_i.op_a >> shamt;
            end
            ALU_SRA: begin
                result = $signed(exe_i.op_a) >>> shamt;
            end
            ALU_OR: begin
                result = exe_i.op_a | exe_i.op_b;
            end
            ALU_AND: begin
                result = exe_i.op_a & exe_i.op_b;
            end
            // immediate already shifted into place by decode
            ALU_LUI: begin
                result = exe_i.op_b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_q.valid <= 1'b0;
        end else begin
            wb_q.valid <= exe_i.valid;
        end
        wb_q.rd    <= exe_i.rd;
        wb_q.value <= (exe_i.rd == '0) ? '0 : result;
    end

    assign wb_o = wb_q;

endmodule

`default_nettype wire

// ==== verilog/kiwi_operands.sv ====
`timescale 1ns/1ps
`default_nettype none

module kiwi_operands import kiwi_pkg::*; (
    input  wire          clk,
    input  wire          rst_n_i,
    input  wire dec_op_t issue_i,
    input  wire wb_t     wb_i,
    output exe_op_t      exe_o
);

    logic [XLEN-1:0] rf_q [NUM_REGS];
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_b;
    exe_op_t         exe_q;

    // architectural state, cleared on reset
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                rf_q[i] <= '0;
            end
        end else if (wb_i.valid && wb_i.rd != '0) begin
            rf_q[wb_i.rd] <= wb_i.value;
        end
    end

    // x0 reads zero
    assign rs1_val = (issue_i.rs1 == '0) ? '0 : rf_q[issue_i.rs1];
    assign rs2_val = (issue_i.rs2 == '0) ? '0 : rf_q[issue_i.rs2];

    assign op_b = issue_i.use_imm ? issue_i.imm : rs2_val;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            exe_q.valid <= 1'b0;
        end else begin
            exe_q.valid <= issue_i.valid;
        end
        exe_q.alu_op <= issue_i.alu_op;
        exe_q.rd     <= issue_i.rd;
        exe_q.op_a   <= rs1_val;
        exe_q.op_b   <= op_b;
    end

    assign exe_o = exe_q;

endmodule

`default_nettype wire

// ==== verilog/kiwi_scoreboard.sv ====
`timescale 1ns/1ps
`default_nettype none

module kiwi_scoreboard import kiwi_pkg::*; (
    input  wire                  clk,
    input  wire                  rst_n_i,
    input  wire [REG_ADDR_W-1:0] src_rs1_i,
    input  wire [REG_ADDR_W-1:0] src_rs2_i,
    input  wire                  src_use1_i,
    input  wire                  src_use2_i,
    input  wire dec_op_t         issue_i,
    input  wire wb_t             wb_i,
    output logic                 hazard_o
);

    logic [PEND_CNT_W-1:0] pend_cnt_q [NUM_REGS];
    logic [NUM_REGS-1:0]   pending;
    logic                  set_en;
    logic                  clr_en;

    assign set_en = issue_i.valid && (issue_i.rd != '0);
    assign clr_en = wb_i.valid && (wb_i.rd != '0);

    // count writers per register, so back-to-back writes to one rd stay pending
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_REGS; i++) begin
            if (!rst_n_i) begin
                pend_cnt_q[i] <= '0;
            end else if (set_en && issue_i.rd == REG_ADDR_W'(i)
                         && !(clr_en && wb_i.rd == REG_ADDR_W'(i))) begin
                pend_cnt_q[i] <= pend_cnt_q[i] + 1'b1;
            end else if (clr_en && wb_i.rd == REG_ADDR_W'(i)
                         && !(set_en && issue_i.rd == REG_ADDR_W'(i))) begin
                pend_cnt_q[i] <= pend_cnt_q[i] - 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_REGS; i++) begin
            pending[i] = (pend_cnt_q[i] != '0);
        end
    end

    assign hazard_o = (src_use1_i && pending[src_rs1_i])
                   || (src_use2_i && pending[src_rs2_i]);

    // every retiring write was marked at issue
    assert property (@(posedge clk) disable iff (!rst_n_i)
        clr_en |-> pending[wb_i.rd]);

endmodule

`default_nettype wire

// ==== verilog/kiwi_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module kiwi_decoder import kiwi_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n_i,
    input  wire                   inst_valid_i,
    input  wire [ILEN-1:0]        inst_i,
    output logic                  inst_ready_o,
    input  wire                   hazard_i,
    output logic [REG_ADDR_W-1:0] src_rs1_o,
    output logic [REG_ADDR_W-1:0] src_rs2_o,
    output logic                  src_use1_o,
    output logic                  src_use2_o,
    output dec_op_t               issue_o
);

    logic [ILEN-1:0]       inst_q;
    logic                  inst_vld_q;
    logic                  accept;
    logic                  drain;
    opcode_e               opcode;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic                  is_op;
    logic                  is_imm;
    logic                  is_lui;
    logic                  known;
    logic [XLEN-1:0]       i_imm;
    logic [XLEN-1:0]       u_imm;
    alu_op_e               alu_op;

    // leaves decode this edge whether the opcode is known or not
    assign drain        = inst_vld_q && !hazard_i;
    assign inst_ready_o = !inst_vld_q || !hazard_i;
    assign accept       = inst_valid_i && inst_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            inst_vld_q <= 1'b0;
        end else if (accept) begin
            inst_vld_q <= 1'b1;
        end else if (drain) begin
            inst_vld_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inst_q <= inst_i;
        end
    end

    assign opcode = opcode_e'(inst_q[6:0]);
    assign rd     = inst_q[11:7];
    assign funct3 = inst_q[14:12];
    assign rs1    = inst_q[19:15];
    assign rs2    = inst_q[24:20];
    assign funct7 = inst_q[31:25];

    assign is_op  = (opcode == OPC_OP);
    assign is_imm = (opcode == OPC_OP_IMM);
    assign is_lui = (opcode == OPC_LUI);
    assign known  = is_op || is_imm || is_lui;

    assign i_imm = {{(XLEN-12){inst_q[31]}}, inst_q[31:20]};
    assign u_imm = {{(XLEN-32){inst_q[31]}}, inst_q[31:12], 12'b0};

    // funct7 bit 5 picks SRA in both formats and SUB in OP only
    always_comb begin
        case (funct3)
            3'b000:  alu_op = (is_op && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
        if (is_lui) begin
            alu_op = ALU_LUI;
        end
    end

    assign src_use1_o = inst_vld_q && (is_op || is_imm);
    assign src_use2_o = inst_vld_q && is_op;
    assign src_rs1_o  = rs1;
    assign src_rs2_o  = rs2;

    always_comb begin
        issue_o.valid   = drain && known;
        issue_o.alu_op  = alu_op;
        issue_o.rd      = (inst_vld_q && known) ? rd : '0;
        issue_o.rs1     = src_use1_o ? rs1 : '0;
        issue_o.rs2     = src_use2_o ? rs2 : '0;
        issue_o.use_imm = !is_op;
        issue_o.imm     = is_lui ? u_imm : i_imm;
    end

    // an offered instruction stays valid and unchanged until it is taken
    assert property (@(posedge clk) disable iff (!rst_n_i)
        inst_valid_i && !inst_ready_o |=> inst_valid_i && $stable(inst_i));

endmodule

`default_nettype wire

// ==== verilog/kiwi_pkg.sv ====
`default_nettype none

package kiwi_pkg;

    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    // RV64 shifts take six bits of shamt
    localparam int SHAMT_W    = 6;
    // at most two writers in flight past decode
    localparam int PEND_CNT_W = 2;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic                  valid;
        alu_op_e               alu_op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  use_imm;
        logic [XLEN-1:0]       imm;
    } dec_op_t;

    typedef struct packed {
        logic                  valid;
        alu_op_e               alu_op;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       op_a;
        logic [XLEN-1:0]       op_b;
    } exe_op_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
    } wb_t;

endpackage

`default_nettype wire
